//--- hdl/btc_spc_pkg.sv
// SPC soft decoder shared widths, sample types and saturating arithmetic
package btc_spc_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int LLR_W      = 5;
  localparam int EXTR_W     = 6;
  localparam int ALPHA_W    = 5;
  localparam int ERR_W      = 16;
  // magnitude of a saturated soft value
  localparam int MAG_W      = EXTR_W - 1;
  // alpha unit is 1/16
  localparam int ALPHA_FRAC = 4;

  typedef logic signed [LLR_W-1:0]   llr_t;
  typedef logic signed [EXTR_W-1:0]  extr_t;
  typedef logic        [MAG_W-1:0]   mag_t;
  typedef logic        [ALPHA_W-1:0] alpha_t;
  typedef logic        [ERR_W-1:0]   err_cnt_t;

  // symmetric clamp, -32 never produced
  localparam extr_t SAT_POS = extr_t'(31);
  localparam extr_t SAT_NEG = extr_t'(-31);

  // ------------------------------
  // stream structs
  // ------------------------------
  typedef struct packed {
    logic sof;
    logic eop;
    logic mask;
  } strb_t;

  typedef struct packed {
    extr_t sum;
    logic  chan_bit;
  } lane_sample_t;

  typedef struct packed {
    extr_t lextr;
    logic  bitdat;
    logic  biterr;
    logic  decfail;
  } lane_result_t;

  // signed add with clamp to +/-31
  function automatic extr_t sat_add(input extr_t a, input extr_t b);
    logic signed [EXTR_W:0] full;
    full = a + b;
    if (full > SAT_POS) return SAT_POS;
    if (full < SAT_NEG) return SAT_NEG;
    return full[EXTR_W-1:0];
  endfunction

  // mag * alpha / 16, clamped to max magnitude
  function automatic mag_t scale_mag(input mag_t mag, input alpha_t alpha);
    logic [MAG_W+ALPHA_W-1:0] prod;
    prod = mag * alpha;
    prod = prod >> ALPHA_FRAC;
    if (prod > {MAG_W{1'b1}}) return '1;
    return prod[MAG_W-1:0];
  endfunction

endpackage

//--- hdl/btc_lane_feeder.sv
// source stage, registers the input word and forms per-lane soft sums
`timescale 1ns/100ps

module btc_lane_feeder #(
  parameter int pDEC_NUM = 8
) (
  input  logic                                      iclk,
  input  logic                                      ireset,
  input  logic                                      ival,
  input  btc_spc_pkg::strb_t                        istrb,
  input  btc_spc_pkg::alpha_t                       ialpha,
  input  btc_spc_pkg::llr_t         [pDEC_NUM-1:0]  illr,
  input  btc_spc_pkg::extr_t        [pDEC_NUM-1:0]  ilextr,
  output logic                                      oval,
  output btc_spc_pkg::strb_t                        ostrb,
  output btc_spc_pkg::alpha_t                       oalpha,
  output btc_spc_pkg::lane_sample_t [pDEC_NUM-1:0]  osample
);

  // frame tracker, only for stream checks
  logic in_frame;

  // ------------------------------
  // valid pipe
  // ------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval     <= 1'b0;
      in_frame <= 1'b0;
    end else begin
      oval <= ival;
      if (ival) begin
        // eop closes, sof opens
        if (istrb.eop) begin
          in_frame <= 1'b0;
        end else if (istrb.sof) begin
          in_frame <= 1'b1;
        end
      end
    end
  end

  // ------------------------------
  // payload, loaded per valid word
  // ------------------------------
  always_ff @(posedge iclk) begin
    if (ival) begin
      ostrb  <= istrb;
      oalpha <= ialpha;
      for (int i = 0; i < pDEC_NUM; i++) begin
        // channel + prior extrinsic, saturated
        osample[i].sum      <= btc_spc_pkg::sat_add(illr[i], ilextr[i]);
        // hard bit from channel sign
        osample[i].chan_bit <= illr[i][btc_spc_pkg::LLR_W-1];
      end
    end
  end

  // a new frame must not start inside another one
  a_sof_outside_frame : assert property (
    @(posedge iclk) disable iff (ireset)
    (ival && istrb.sof) |-> !in_frame
  ) else $error("feeder: sof inside a frame");

endmodule

//--- hdl/btc_spc_engine.sv
// one lane SPC min-sum engine with ping-pong sample buffer
`timescale 1ns/100ps

module btc_spc_engine #(
  parameter int pCODE_LEN = 16
) (
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      ival,
  input  btc_spc_pkg::strb_t        istrb,
  input  btc_spc_pkg::alpha_t       ialpha,
  input  btc_spc_pkg::lane_sample_t isample,
  output logic                      oval,
  output btc_spc_pkg::strb_t        ostrb,
  output btc_spc_pkg::lane_result_t oresult
);

  localparam int IDX_W = $clog2(pCODE_LEN);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(pCODE_LEN - 1);
  localparam int SGN = btc_spc_pkg::EXTR_W - 1;

  typedef enum logic {
    state_idle,
    state_emit
  } state_t;

  // running or latched codeword statistics
  typedef struct packed {
    btc_spc_pkg::mag_t  min1;
    btc_spc_pkg::mag_t  min2;
    logic [IDX_W-1:0]   pos;
    logic               sgn;
  } frame_stat_t;

  // two frame halves
  btc_spc_pkg::lane_sample_t mem [2][pCODE_LEN];

  logic                wr_half;
  logic [IDX_W-1:0]    wr_idx;
  logic [IDX_W-1:0]    wr_addr;
  btc_spc_pkg::mag_t   smp_mag;
  frame_stat_t         acc_stat;
  frame_stat_t         nx_stat;

  state_t              state;
  logic                rd_half;
  logic [IDX_W-1:0]    rd_idx;
  frame_stat_t         f_stat;
  btc_spc_pkg::alpha_t f_alpha;
  logic                f_mask;

  btc_spc_pkg::lane_sample_t rd_smp;
  btc_spc_pkg::mag_t         oth_mag;
  btc_spc_pkg::mag_t         ext_mag;
  btc_spc_pkg::extr_t        ext_val;
  btc_spc_pkg::extr_t        tot;

  // ------------------------------
  // write side and min search
  // ------------------------------
  assign wr_addr = istrb.sof ? '0 : wr_idx;

  always_comb begin
    // |sum| <= 31 after feeder saturation
    smp_mag = isample.sum[SGN] ? btc_spc_pkg::mag_t'(-isample.sum)
                               : btc_spc_pkg::mag_t'(isample.sum);
    if (istrb.sof) begin
      nx_stat.min1 = smp_mag;
      nx_stat.min2 = '1;
      nx_stat.pos  = '0;
      nx_stat.sgn  = isample.sum[SGN];
    end else begin
      nx_stat     = acc_stat;
      nx_stat.sgn = acc_stat.sgn ^ isample.sum[SGN];
      if (smp_mag < acc_stat.min1) begin
        nx_stat.min2 = acc_stat.min1;
        nx_stat.min1 = smp_mag;
        nx_stat.pos  = wr_addr;
      end else if (smp_mag < acc_stat.min2) begin
        nx_stat.min2 = smp_mag;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (ival) begin
      mem[wr_half][wr_addr] <= isample;
      acc_stat              <= nx_stat;
    end
    // frame statistics frozen at eop
    if (ival && istrb.eop) begin
      f_stat  <= nx_stat;
      f_alpha <= ialpha;
      f_mask  <= istrb.mask;
    end
  end

  // ------------------------------
  // half swap and read FSM
  // ------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_half <= 1'b0;
      wr_idx  <= '0;
      rd_half <= 1'b0;
      rd_idx  <= '0;
      state   <= state_idle;
    end else begin
      if (ival) begin
        wr_idx <= wr_addr + 1'b1;
      end
      if (ival && istrb.eop) begin
        // read the half just filled, fill the other
        wr_half <= ~wr_half;
        rd_half <= wr_half;
        rd_idx  <= '0;
        state   <= state_emit;
      end else if (state == state_emit) begin
        if (rd_idx == LAST_IDX) begin
          state <= state_idle;
        end else begin
          rd_idx <= rd_idx + 1'b1;
        end
      end
    end
  end

  // ------------------------------
  // extrinsic per sample
  // ------------------------------
  always_comb begin
    rd_smp  = mem[rd_half][rd_idx];
    // exclude the sample's own magnitude
    oth_mag = (rd_idx == f_stat.pos) ? f_stat.min2 : f_stat.min1;
    ext_mag = btc_spc_pkg::scale_mag(oth_mag, f_alpha);
    ext_val = btc_spc_pkg::extr_t'(ext_mag);
    if (f_stat.sgn ^ rd_smp.sum[SGN]) begin
      ext_val = -ext_val;
    end
    tot = btc_spc_pkg::sat_add(rd_smp.sum, ext_val);
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end else begin
      oval <= (state == state_emit);
    end
  end

  always_ff @(posedge iclk) begin
    ostrb.sof       <= (rd_idx == '0);
    ostrb.eop       <= (rd_idx == LAST_IDX);
    ostrb.mask      <= f_mask;
    oresult.lextr   <= ext_val;
    oresult.bitdat  <= tot[SGN];
    oresult.biterr  <= tot[SGN] ^ rd_smp.chan_bit;
    // odd sign parity means the check failed
    oresult.decfail <= f_stat.sgn;
  end

  // codeword length is fixed by the parameter
  a_eop_at_last : assert property (
    @(posedge iclk) disable iff (ireset)
    (ival && istrb.eop) |-> (wr_addr == LAST_IDX)
  ) else $error("engine: eop not on sample %0d", pCODE_LEN);

endmodule

//--- hdl/btc_lane_collector.sv
// sink stage, registers lane results, counts bit errors and tracks failure
`timescale 1ns/100ps

module btc_lane_collector #(
  parameter int pDEC_NUM = 8
) (
  input  logic                                     iclk,
  input  logic                                     ireset,
  input  logic                                     istart,
  input  logic                      [pDEC_NUM-1:0] ival,
  input  btc_spc_pkg::strb_t        [pDEC_NUM-1:0] istrb,
  input  btc_spc_pkg::lane_result_t [pDEC_NUM-1:0] iresult,
  output logic                                     oval,
  output btc_spc_pkg::strb_t                       ostrb,
  output btc_spc_pkg::extr_t        [pDEC_NUM-1:0] olextr,
  output logic                      [pDEC_NUM-1:0] obitdat,
  output btc_spc_pkg::err_cnt_t                    obiterr,
  output logic                                     odecfail
);

  btc_spc_pkg::err_cnt_t lane_errs;
  btc_spc_pkg::err_cnt_t err_acc;
  logic [pDEC_NUM-1:0]   lane_fail;
  logic                  frame_fail;
  logic                  done_pend;
  logic                  fail_pend;
  logic                  strb_same;

  // ------------------------------
  // per-cycle lane reduction
  // ------------------------------
  always_comb begin
    lane_errs = '0;
    strb_same = 1'b1;
    for (int i = 0; i < pDEC_NUM; i++) begin
      lane_errs    = lane_errs + btc_spc_pkg::err_cnt_t'(ival[i] & iresult[i].biterr);
      lane_fail[i] = ival[i] & iresult[i].decfail;
      if (istrb[i] != istrb[0] || ival[i] != ival[0]) begin
        strb_same = 1'b0;
      end
    end
    // masked frames never count
    frame_fail = ival[0] & istrb[0].eop & ~istrb[0].mask & (|lane_fail);
  end

  // output register
  always_ff @(posedge iclk) begin
    ostrb <= istrb[0];
    for (int i = 0; i < pDEC_NUM; i++) begin
      olextr[i]  <= iresult[i].lextr;
      obitdat[i] <= iresult[i].bitdat;
    end
    // sof restarts the frame sum
    if (ival[0]) begin
      err_acc <= (istrb[0].sof ? '0 : err_acc) + lane_errs;
    end
  end

  // ------------------------------
  // frame close, one cycle after eop
  // ------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval      <= 1'b0;
      done_pend <= 1'b0;
      fail_pend <= 1'b0;
      obiterr   <= '0;
      odecfail  <= 1'b0;
    end else begin
      oval      <= ival[0];
      done_pend <= ival[0] & istrb[0].eop;
      fail_pend <= frame_fail;
      if (done_pend) begin
        obiterr <= err_acc;
      end
      // start wins over a closing frame
      if (istart) begin
        odecfail <= 1'b0;
      end else if (fail_pend) begin
        odecfail <= 1'b1;
      end
    end
  end

  // engines run in lockstep
  a_lanes_lockstep : assert property (
    @(posedge iclk) disable iff (ireset)
    (|ival) |-> strb_same
  ) else $error("collector: lanes out of step");

endmodule

//--- hdl/btc_spc_decoder.sv
// SPC component code soft decoder top, feeder to lane engines to collector
`timescale 1ns/100ps

module btc_spc_decoder #(
  parameter int pDEC_NUM  = 8,
  parameter int pCODE_LEN = 16
) (
  input  logic                                iclk,
  input  logic                                ireset,
  input  logic                                istart,
  input  btc_spc_pkg::alpha_t                 ialpha,
  input  logic                                ival,
  input  btc_spc_pkg::strb_t                  istrb,
  input  btc_spc_pkg::llr_t    [pDEC_NUM-1:0] illr,
  input  btc_spc_pkg::extr_t   [pDEC_NUM-1:0] ilextr,
  output logic                                oval,
  output btc_spc_pkg::strb_t                  ostrb,
  output btc_spc_pkg::extr_t   [pDEC_NUM-1:0] olextr,
  output logic                 [pDEC_NUM-1:0] obitdat,
  output btc_spc_pkg::err_cnt_t               obiterr,
  output logic                                odecfail
);

  // feeder to engines, shared
  logic                                     feed_val;
  btc_spc_pkg::strb_t                       feed_strb;
  btc_spc_pkg::alpha_t                      feed_alpha;
  btc_spc_pkg::lane_sample_t [pDEC_NUM-1:0] feed_sample;

  // engines to collector, one per lane
  logic                      [pDEC_NUM-1:0] eng_val;
  btc_spc_pkg::strb_t        [pDEC_NUM-1:0] eng_strb;
  btc_spc_pkg::lane_result_t [pDEC_NUM-1:0] eng_result;

  // ------------------------------
  // source
  // ------------------------------
  btc_lane_feeder #(
    .pDEC_NUM (pDEC_NUM)
  ) feeder_i (
    .iclk    (iclk),
    .ireset  (ireset),
    .ival    (ival),
    .istrb   (istrb),
    .ialpha  (ialpha),
    .illr    (illr),
    .ilextr  (ilextr),
    .oval    (feed_val),
    .ostrb   (feed_strb),
    .oalpha  (feed_alpha),
    .osample (feed_sample)
  );

  // ------------------------------
  // lane engines
  // ------------------------------
  for (genvar g = 0; g < pDEC_NUM; g++) begin : lane_gen
    btc_spc_engine #(
      .pCODE_LEN (pCODE_LEN)
    ) engine_i (
      .iclk    (iclk),
      .ireset  (ireset),
      .ival    (feed_val),
      .istrb   (feed_strb),
      .ialpha  (feed_alpha),
      .isample (feed_sample[g]),
      .oval    (eng_val[g]),
      .ostrb   (eng_strb[g]),
      .oresult (eng_result[g])
    );
  end

  // ------------------------------
  // sink
  // ------------------------------
  btc_lane_collector #(
    .pDEC_NUM (pDEC_NUM)
  ) collector_i (
    .iclk     (iclk),
    .ireset   (ireset),
    .istart   (istart),
    .ival     (eng_val),
    .istrb    (eng_strb),
    .iresult  (eng_result),
    .oval     (oval),
    .ostrb    (ostrb),
    .olextr   (olextr),
    .obitdat  (obitdat),
    .obiterr  (obiterr),
    .odecfail (odecfail)
  );

endmodule

//--- verification/btc_clock_gen.sv
// testbench clock and power-on reset source
`timescale 1ns/100ps

module btc_clock_gen #(
  parameter real pPERIOD       = 8.0,
  parameter int  pRESET_CYCLES = 10
) (
  output logic iclk,
  output logic ireset
);

  // free running clock
  initial begin
    iclk = 1'b0;
    forever #(pPERIOD / 2.0) iclk = ~iclk;
  end

  // reset held for a fixed number of edges
  initial begin
    ireset = 1'b1;
    repeat (pRESET_CYCLES) @(posedge iclk);
    ireset <= 1'b0;
  end

endmodule

//--- verification/btc_spc_decoder_tb.sv
// SPC decoder testbench checking table driven frames against a min-sum model
`timescale 1ns/100ps

module btc_spc_decoder_tb;

  localparam int pDEC_NUM  = 8;
  localparam int pCODE_LEN = 16;
  localparam int NUM_ROWS  = 12;
  localparam int LAT       = 4;
  localparam int XW        = btc_spc_pkg::EXTR_W;
  localparam int VEC_W     = pDEC_NUM * XW;
  // odd lane value for a codeword with even parity in every lane
  localparam logic [3:0] NO_ODD = 4'hf;

  typedef struct packed {
    logic [7:0] seed_ofs;
    logic [4:0] alpha;
    logic       mask;
    logic       start;
    logic [7:0] gap;
    logic [3:0] odd_lane;
  } frame_row_t;

  logic                                      iclk;
  logic                                      ireset;
  logic                                      istart;
  btc_spc_pkg::alpha_t                       ialpha;
  logic                                      ival;
  btc_spc_pkg::strb_t                        istrb;
  btc_spc_pkg::llr_t        [pDEC_NUM-1:0]   illr;
  btc_spc_pkg::extr_t       [pDEC_NUM-1:0]   ilextr;
  logic                                      oval;
  btc_spc_pkg::strb_t                        ostrb;
  btc_spc_pkg::extr_t       [pDEC_NUM-1:0]   olextr;
  logic                     [pDEC_NUM-1:0]   obitdat;
  btc_spc_pkg::err_cnt_t                     obiterr;
  logic                                      odecfail;
  logic                     [VEC_W-1:0]      olextr_flat;

  frame_row_t         rows      [NUM_ROWS];
  btc_spc_pkg::llr_t  frm_llr   [pCODE_LEN][pDEC_NUM];
  btc_spc_pkg::extr_t frm_lextr [pCODE_LEN][pDEC_NUM];
  logic [31:0]        rng;

  // expected results in output order
  logic [VEC_W-1:0]    exp_lextr_q [$];
  logic [pDEC_NUM-1:0] exp_bits_q  [$];
  int                  exp_cnt_q   [$];
  logic                exp_fail_q  [$];
  logic                exp_mask_q  [$];
  int                  eop_cyc_q   [$];

  int   cyc         = 0;
  int   timeout_limit;
  int   checks      = 0;
  int   value_errs  = 0;
  int   proto_errs  = 0;
  int   frames_done = 0;
  int   out_idx     = 0;
  int   close_cnt   = 0;
  int   lat;
  int   exp_biterr  = 0;
  logic exp_decfail = 1'b0;
  logic close_seen  = 1'b0;
  logic fail_seen   = 1'b0;
  logic start_seen  = 1'b0;

  btc_clock_gen #(
    .pPERIOD       (8.0),
    .pRESET_CYCLES (10)
  ) clock_gen_i (
    .iclk   (iclk),
    .ireset (ireset)
  );

  btc_spc_decoder #(
    .pDEC_NUM  (pDEC_NUM),
    .pCODE_LEN (pCODE_LEN)
  ) dut_i (
    .iclk     (iclk),
    .ireset   (ireset),
    .istart   (istart),
    .ialpha   (ialpha),
    .ival     (ival),
    .istrb    (istrb),
    .illr     (illr),
    .ilextr   (ilextr),
    .oval     (oval),
    .ostrb    (ostrb),
    .olextr   (olextr),
    .obitdat  (obitdat),
    .obiterr  (obiterr),
    .odecfail (odecfail)
  );

  assign olextr_flat = olextr;

  always @(posedge iclk) begin
    cyc <= cyc + 1;
  end

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int clamp31(input int v);
    if (v > 31) return 31;
    if (v < -31) return -31;
    return v;
  endfunction

  function automatic int max_gap();
    int m;
    m = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].gap > m) begin
        m = rows[r].gap;
      end
    end
    return m;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp, cyc);
    end
  endtask

  task automatic report_problem(input string what);
    proto_errs++;
    $display("error at cycle %0d: %s", cyc, what);
  endtask

  task automatic set_row(input int idx, input int ofs, input int alpha,
                         input bit mask, input bit start, input int gap,
                         input int odd);
    rows[idx].seed_ofs = ofs;
    rows[idx].alpha    = alpha;
    rows[idx].mask     = mask;
    rows[idx].start    = start;
    rows[idx].gap      = gap;
    rows[idx].odd_lane = odd;
  endtask

  task automatic load_table();
    //         seed alpha mask start gap  odd lane
    set_row(0,  0,  16,   0,   0,    0,  3);
    // clean codeword keeps the flag set
    set_row(1,  1,  12,   0,   0,    0,  NO_ODD);
    // lane 0 extrinsic clamps at 31 with alpha near 2
    set_row(2,  2,  31,   0,   0,    3,  7);
    set_row(3,  3,   8,   1,   0,   24,  0);
    // start after drain while masked frames keep the flag low
    set_row(4,  4,  24,   1,   1,    0,  5);
    set_row(5,  5,  20,   1,   0,   24,  2);
    // even parity everywhere leaves the cleared flag low
    set_row(6,  6,  16,   0,   0,    2,  NO_ODD);
    set_row(7,  7,  28,   0,   0,    0,  0);
    set_row(8,  8,   0,   0,   0,    5,  4);
    // start while the previous frame still drains
    set_row(9,  9,  31,   0,   1,    0,  6);
    set_row(10, 10, 14,   1,   0,    1,  1);
    set_row(11, 11, 16,   0,   0,    4,  NO_ODD);
  endtask

  // ------------------------------
  // reference model
  // ------------------------------
  task automatic build_frame(input frame_row_t row);
    int                  sum_v [pCODE_LEN];
    int                  mag_v [pCODE_LEN];
    logic [VEC_W-1:0]    lex_v [pCODE_LEN];
    logic [pDEC_NUM-1:0] bit_v [pCODE_LEN];
    logic [pDEC_NUM-1:0] par_v;
    logic                neg;
    int                  pos;
    int                  min2;
    int                  oth;
    int                  ext;
    int                  cnt;
    logic                par;
    logic                fail;
    logic                bitd;
    cnt   = 0;
    fail  = 1'b0;
    par_v = '0;
    rng   = 32'd34 + row.seed_ofs;
    repeat (4) rng = xorshift(rng);
    for (int k = 0; k < pCODE_LEN; k++) begin
      for (int ln = 0; ln < pDEC_NUM; ln++) begin
        rng = xorshift(rng);
        frm_llr[k][ln]   = rng[4:0];
        frm_lextr[k][ln] = rng[12:7];
        // confident samples in lane 0 and a parity sample at the end of each lane
        if (ln == 0 || k == pCODE_LEN - 1) begin
          if (ln == 0) begin
            frm_llr[k][ln]   = btc_spc_pkg::llr_t'(12 + rng[1:0]);
            frm_lextr[k][ln] = btc_spc_pkg::extr_t'(8 + rng[10:7]);
          end else begin
            frm_llr[k][ln]   = btc_spc_pkg::llr_t'(1 + rng[2:0]);
            frm_lextr[k][ln] = btc_spc_pkg::extr_t'(rng[10:7]);
          end
          neg = rng[4];
          if (k == pCODE_LEN - 1) begin
            // only the chosen lane ends with odd sign parity
            neg = par_v[ln] ^ (ln == int'(row.odd_lane));
          end
          if (neg) begin
            frm_llr[k][ln]   = -frm_llr[k][ln];
            frm_lextr[k][ln] = -frm_lextr[k][ln];
          end
        end
        par_v[ln] = par_v[ln] ^ ((int'(frm_llr[k][ln]) + int'(frm_lextr[k][ln])) < 0);
      end
    end
    for (int ln = 0; ln < pDEC_NUM; ln++) begin
      par  = 1'b0;
      pos  = 0;
      min2 = 31;
      // soft sums, sign parity and first smallest magnitude
      for (int k = 0; k < pCODE_LEN; k++) begin
        sum_v[k] = clamp31(int'(frm_llr[k][ln]) + int'(frm_lextr[k][ln]));
        mag_v[k] = (sum_v[k] < 0) ? -sum_v[k] : sum_v[k];
        par      = par ^ (sum_v[k] < 0);
        if (mag_v[k] < mag_v[pos]) begin
          pos = k;
        end
      end
      for (int k = 0; k < pCODE_LEN; k++) begin
        if (k != pos && mag_v[k] < min2) begin
          min2 = mag_v[k];
        end
      end
      // extrinsic from the other samples
      for (int k = 0; k < pCODE_LEN; k++) begin
        oth = (k == pos) ? min2 : mag_v[pos];
        ext = (oth * int'(row.alpha)) >> 4;
        if (ext > 31) begin
          ext = 31;
        end
        if (par ^ (sum_v[k] < 0)) begin
          ext = -ext;
        end
        bitd = (sum_v[k] + ext) < 0;
        lex_v[k][ln*XW +: XW] = ext[XW-1:0];
        bit_v[k][ln] = bitd;
        cnt = cnt + int'(bitd ^ frm_llr[k][ln][btc_spc_pkg::LLR_W-1]);
      end
      fail = fail | par;
    end
    for (int k = 0; k < pCODE_LEN; k++) begin
      exp_lextr_q.push_back(lex_v[k]);
      exp_bits_q.push_back(bit_v[k]);
    end
    exp_cnt_q.push_back(cnt);
    exp_fail_q.push_back(fail & ~row.mask);
    exp_mask_q.push_back(row.mask);
  endtask

  // ------------------------------
  // output monitor on the falling edge
  // ------------------------------
  always @(negedge iclk) begin
    if (!ireset) begin
      if (ival && istrb.eop) begin
        eop_cyc_q.push_back(cyc);
      end
      // frame close and start seen last cycle
      if (close_seen) begin
        exp_biterr = close_cnt;
      end
      if (start_seen) begin
        exp_decfail = 1'b0;
      end else if (fail_seen) begin
        exp_decfail = 1'b1;
      end
      check_value("obiterr", obiterr, exp_biterr);
      check_value("odecfail", odecfail, exp_decfail);
      close_seen = 1'b0;
      fail_seen  = 1'b0;
      start_seen = istart;
      if (oval) begin
        if (exp_lextr_q.size() == 0) begin
          report_problem("output sample with no frame pending");
        end else begin
          if (out_idx == 0) begin
            if (eop_cyc_q.size() == 0) begin
              report_problem("output frame began before its input eop");
            end else begin
              lat = cyc - eop_cyc_q.pop_front();
              check_value("latency", lat, LAT);
            end
          end
          check_value("ostrb.sof", ostrb.sof, out_idx == 0);
          check_value("ostrb.eop", ostrb.eop, out_idx == pCODE_LEN - 1);
          check_value("ostrb.mask", ostrb.mask, exp_mask_q[0]);
          check_value("olextr", olextr_flat, exp_lextr_q.pop_front());
          check_value("obitdat", obitdat, exp_bits_q.pop_front());
          if (out_idx == pCODE_LEN - 1) begin
            close_seen = 1'b1;
            close_cnt  = exp_cnt_q.pop_front();
            fail_seen  = exp_fail_q.pop_front();
            void'(exp_mask_q.pop_front());
            frames_done++;
            out_idx = 0;
          end else begin
            out_idx++;
          end
        end
      end else if (out_idx != 0) begin
        report_problem("oval dropped inside an output frame");
        out_idx = 0;
      end
    end
  end

  // ------------------------------
  // timeout
  // ------------------------------
  initial begin
    @(posedge iclk);
    timeout_limit = NUM_ROWS * (2 * pCODE_LEN + max_gap()) + 100;
    wait (cyc >= timeout_limit);
    $display("timeout: run did not finish within %0d cycles", timeout_limit);
    $display("STATUS: FAIL");
    $finish;
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    ival   = 1'b0;
    istrb  = '0;
    istart = 1'b0;
    ialpha = '0;
    illr   = '0;
    ilextr = '0;
    load_table();
    @(negedge ireset);
    // idle outputs straight after reset
    @(negedge iclk);
    check_value("oval", oval, 1'b0);
    check_value("odecfail", odecfail, 1'b0);
    check_value("obiterr", obiterr, 0);
    for (int r = 0; r < NUM_ROWS; r++) begin
      build_frame(rows[r]);
      for (int k = 0; k < pCODE_LEN; k++) begin
        @(posedge iclk);
        ival       <= 1'b1;
        istrb.sof  <= (k == 0);
        istrb.eop  <= (k == pCODE_LEN - 1);
        istrb.mask <= rows[r].mask;
        istart     <= rows[r].start && (k == 0);
        ialpha     <= rows[r].alpha;
        for (int ln = 0; ln < pDEC_NUM; ln++) begin
          illr[ln]   <= frm_llr[k][ln];
          ilextr[ln] <= frm_lextr[k][ln];
        end
      end
      repeat (rows[r].gap) begin
        @(posedge iclk);
        ival   <= 1'b0;
        istart <= 1'b0;
      end
    end
    @(posedge iclk);
    ival   <= 1'b0;
    istart <= 1'b0;
    wait (frames_done == NUM_ROWS);
    // let obiterr and odecfail settle
    repeat (3) @(posedge iclk);
    if (exp_lextr_q.size() != 0 || eop_cyc_q.size() != 0) begin
      report_problem("expected output samples never appeared");
    end
    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
hdl/btc_spc_pkg.sv
hdl/btc_lane_feeder.sv
hdl/btc_spc_engine.sv
hdl/btc_lane_collector.sv
hdl/btc_spc_decoder.sv
verification/btc_clock_gen.sv
verification/btc_spc_decoder_tb.sv

//--- Bender.yml
package:
  name: btc_spc_decoder

sources:
  - hdl/btc_spc_pkg.sv
  - hdl/btc_lane_feeder.sv
  - hdl/btc_spc_engine.sv
  - hdl/btc_lane_collector.sv
  - hdl/btc_spc_decoder.sv
  - target: test
    files:
      - verification/btc_clock_gen.sv
      - verification/btc_spc_decoder_tb.sv
